//--- Makefile
# Verilator build, run and lint for the capture board register core

VERILATOR ?= verilator
FILELIST  ?= husky_top.f
TB_TOP    ?= tb_husky
RTL_TOP   ?= husky_top
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- capture/la_capture.sv
`default_nettype none

module la_capture (
   input  wire                  clk_usb_buf,
   input  wire                  rst_i,
   reg_bus_if.peer              bus,
   input  wire husky_pkg::sample_t la_probe_i,
   output husky_pkg::reg_data_t rdata_o,
   output logic                 la_wr_o,
   output husky_pkg::sample_t   la_data_o,
   output logic                 armed_o
);
   import husky_pkg::*;

   la_state_t state_q;
   reg_data_t samples_q; // samples per arm
   reg_data_t remain_q; // samples still to take
   logic ctrl_wr;
   logic samples_wr;

   assign ctrl_wr = bus.write && (bus.addr == REG_LA_CTRL);
   assign samples_wr = bus.write && (bus.addr == REG_LA_SAMPLES);

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         samples_q <= '0;
      end else if (samples_wr) begin
         samples_q <= bus.wdata;
      end
   end

   // armed stays up one edge past the last sample
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         state_q <= LA_IDLE;
         remain_q <= '0;
      end else if (ctrl_wr) begin
         if (bus.wdata[0]) begin
            state_q <= LA_CAPTURE;
            remain_q <= samples_q; // length latched at arming
         end else begin
            state_q <= LA_IDLE; // abort
         end
      end else if (state_q == LA_CAPTURE) begin
         if (remain_q == '0) begin
            state_q <= LA_IDLE;
         end else begin
            remain_q <= remain_q - 1'b1;
         end
      end
   end

   assign armed_o = (state_q == LA_CAPTURE);

   // probe goes straight into the FIFO on each sampling edge
   assign la_wr_o = armed_o && (remain_q != '0);
   assign la_data_o = la_probe_i;

   always_comb begin
      case (bus.addr)
         REG_LA_CTRL: rdata_o = {7'b0, armed_o};
         REG_LA_SAMPLES: rdata_o = samples_q;
         default: rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- capture/trace_capture.sv
`default_nettype none

module trace_capture (
   input  wire                  clk_usb_buf,
   input  wire                  rst_i,
   reg_bus_if.peer              bus,
   input  wire husky_pkg::nibble_t trace_data_i,
   input  wire                  trace_valid_i,
   output husky_pkg::reg_data_t rdata_o,
   output logic                 capture_on_o,
   output logic                 trace_wr_o,
   output husky_pkg::sample_t   trace_data_o
);
   import husky_pkg::*;

   reg_data_t ctrl_q; // bit0 is capture on
   nibble_t low_q; // first half of the byte
   logic half_q; // low nibble held
   logic ctrl_wr;
   logic take;

   assign ctrl_wr = bus.write && (bus.addr == REG_TRACE_CTRL);
   assign capture_on_o = ctrl_q[0];
   assign take = capture_on_o && trace_valid_i;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         ctrl_q <= '0;
      end else if (ctrl_wr) begin
         ctrl_q <= bus.wdata;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         half_q <= 1'b0;
         trace_wr_o <= 1'b0;
      end else begin
         trace_wr_o <= take && half_q; // byte complete
         if (ctrl_wr && !bus.wdata[0]) begin
            half_q <= 1'b0; // drop a partial byte
         end else if (take) begin
            half_q <= ~half_q;
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (take && !half_q) begin
         low_q <= trace_data_i;
      end
      if (take && half_q) begin
         trace_data_o <= {trace_data_i, low_q}; // low nibble first
      end
   end

   assign rdata_o = (bus.addr == REG_TRACE_CTRL) ? ctrl_q : '0;

endmodule

`default_nettype wire

//--- common/husky_pkg.sv
`default_nettype none

package husky_pkg;

   // bus and data widths
   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;
   typedef logic [7:0] sample_t; // one captured byte
   typedef logic [3:0] nibble_t; // trace port unit
   typedef logic [4:0] fifo_count_t; // 0 .. FIFO_DEPTH

   // shared sample FIFO
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = 4; // log2 of depth

   // error LED flashing
   localparam int FLASH_HALF_PERIOD = 8; // cycles per toggle
   localparam int FLASH_CNT_W = 3;

   // register map
   localparam reg_addr_t REG_TRACE_CTRL = 8'h01;
   localparam reg_addr_t REG_LA_CTRL = 8'h02;
   localparam reg_addr_t REG_LA_SAMPLES = 8'h03;
   localparam reg_addr_t REG_FIFO_STATUS = 8'h04;
   localparam reg_addr_t REG_FIFO_COUNT = 8'h05;
   localparam reg_addr_t REG_FIFO_READ = 8'h06; // read pops

   // REG_FIFO_STATUS bits
   localparam int STAT_EMPTY_BIT = 0; // read
   localparam int STAT_FULL_BIT = 1; // read
   localparam int STAT_ERR_BIT = 2; // read
   localparam int STAT_FLUSH_BIT = 0; // write
   localparam int STAT_CLR_ERR_BIT = 1; // write

   typedef enum logic {
      LA_IDLE,
      LA_CAPTURE
   } la_state_t;

endpackage

`default_nettype wire

//--- common/reg_bus_if.sv
`default_nettype none

interface reg_bus_if;
   import husky_pkg::*;

   reg_addr_t addr;
   reg_data_t wdata;
   logic write; // one-cycle strobe
   logic read; // one-cycle strobe

   // register host side
   modport host (
      output addr,
      output wdata,
      output write,
      output read
   );

   // decoding blocks only listen
   modport peer (
      input addr,
      input wdata,
      input write,
      input read
   );

endinterface

`default_nettype wire

//--- fifo/sample_fifo.sv
`default_nettype none

module sample_fifo (
   input  wire                  clk_usb_buf,
   input  wire                  rst_i,
   reg_bus_if.peer              bus,
   input  wire                  capture_on_i,
   input  wire                  trace_wr_i,
   input  wire husky_pkg::sample_t trace_data_i,
   input  wire                  la_wr_i,
   input  wire husky_pkg::sample_t la_data_i,
   output husky_pkg::reg_data_t rdata_o,
   output logic                 error_o
);
   import husky_pkg::*;

   sample_t mem_q [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr_q;
   logic [FIFO_PTR_W-1:0] rd_ptr_q;
   fifo_count_t count_q;
   logic error_q;

   logic src_wr;
   sample_t src_data;
   logic empty;
   logic full;
   logic pop_req;
   logic flush;
   logic clr_err;
   logic do_push;
   logic do_pop;
   logic overflow;

   // trace owns the FIFO while its capture is on, otherwise the LA
   assign src_wr = capture_on_i ? trace_wr_i : la_wr_i;
   assign src_data = capture_on_i ? trace_data_i : la_data_i;

   assign empty = (count_q == '0);
   assign full = (count_q == fifo_count_t'(FIFO_DEPTH));

   assign pop_req = bus.read && (bus.addr == REG_FIFO_READ);
   assign flush = bus.write && (bus.addr == REG_FIFO_STATUS) && bus.wdata[STAT_FLUSH_BIT];
   assign clr_err = bus.write && (bus.addr == REG_FIFO_STATUS) &&
                    bus.wdata[STAT_CLR_ERR_BIT];

   // flush beats any write or pop on the same edge
   assign do_push = src_wr && !full && !flush;
   assign do_pop = pop_req && !empty && !flush;
   assign overflow = src_wr && full && !flush;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end else if (flush) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10: count_q <= count_q + 1'b1;
            2'b01: count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= src_data;
      end
   end

   // sticky until the host clears it, a new overflow wins
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         error_q <= 1'b0;
      end else begin
         error_q <= (error_q && !clr_err) || overflow;
      end
   end

   assign error_o = error_q;

   always_comb begin
      rdata_o = '0;
      case (bus.addr)
         REG_FIFO_STATUS: begin
            rdata_o[STAT_EMPTY_BIT] = empty;
            rdata_o[STAT_FULL_BIT] = full;
            rdata_o[STAT_ERR_BIT] = error_q;
         end
         REG_FIFO_COUNT: rdata_o = reg_data_t'(count_q);
         REG_FIFO_READ: rdata_o = empty ? '0 : mem_q[rd_ptr_q]; // head before the pop
         default: rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- husky_top.f
common/husky_pkg.sv
common/reg_bus_if.sv
rtl/led_status.sv
capture/la_capture.sv
capture/trace_capture.sv
fifo/sample_fifo.sv
rtl/husky_top.sv
tests/tb_husky.sv

//--- rtl/husky_top.sv
`default_nettype none

module husky_top (
   input  wire                  clk_usb_buf,
   input  wire                  rst_i,
   input  wire husky_pkg::reg_addr_t reg_addr_i,
   input  wire husky_pkg::reg_data_t reg_wdata_i,
   input  wire                  reg_write_i,
   input  wire                  reg_read_i,
   input  wire husky_pkg::sample_t la_probe_i,
   input  wire husky_pkg::nibble_t trace_data_i,
   input  wire                  trace_valid_i,
   output husky_pkg::reg_data_t reg_rdata_o,
   output logic                 led_err_o,
   output logic                 led_armed_o
);
   import husky_pkg::*;

   reg_data_t la_rdata;
   reg_data_t trace_rdata;
   reg_data_t fifo_rdata;
   logic capture_on;
   logic trace_wr;
   sample_t trace_byte;
   logic la_wr;
   sample_t la_byte;
   logic armed;
   logic fifo_error;

   reg_bus_if bus ();

   assign bus.addr = reg_addr_i;
   assign bus.wdata = reg_wdata_i;
   assign bus.write = reg_write_i;
   assign bus.read = reg_read_i;

   // peers return zero off their own addresses, so a plain OR merges them
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         reg_rdata_o <= '0;
      end else if (reg_read_i) begin
         reg_rdata_o <= la_rdata | trace_rdata | fifo_rdata;
      end
   end

   la_capture i_la_capture (
      .clk_usb_buf (clk_usb_buf),
      .rst_i       (rst_i),
      .bus         (bus.peer),
      .la_probe_i  (la_probe_i),
      .rdata_o     (la_rdata),
      .la_wr_o     (la_wr),
      .la_data_o   (la_byte),
      .armed_o     (armed)
   );

   trace_capture i_trace_capture (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .bus           (bus.peer),
      .trace_data_i  (trace_data_i),
      .trace_valid_i (trace_valid_i),
      .rdata_o       (trace_rdata),
      .capture_on_o  (capture_on),
      .trace_wr_o    (trace_wr),
      .trace_data_o  (trace_byte)
   );

   sample_fifo i_sample_fifo (
      .clk_usb_buf  (clk_usb_buf),
      .rst_i        (rst_i),
      .bus          (bus.peer),
      .capture_on_i (capture_on),
      .trace_wr_i   (trace_wr),
      .trace_data_i (trace_byte),
      .la_wr_i      (la_wr),
      .la_data_i    (la_byte),
      .rdata_o      (fifo_rdata),
      .error_o      (fifo_error)
   );

   led_status i_led_status (
      .clk_usb_buf  (clk_usb_buf),
      .rst_i        (rst_i),
      .error_i      (fifo_error),
      .armed_i      (armed),
      .capture_on_i (capture_on),
      .led_err_o    (led_err_o),
      .led_armed_o  (led_armed_o)
   );

endmodule

`default_nettype wire

//--- rtl/led_status.sv
`default_nettype none

module led_status (
   input  wire  clk_usb_buf,
   input  wire  rst_i,
   input  wire  error_i,
   input  wire  armed_i,
   input  wire  capture_on_i,
   output logic led_err_o,
   output logic led_armed_o
);
   import husky_pkg::*;

   localparam logic [FLASH_CNT_W-1:0] FLASH_LAST = FLASH_CNT_W'(FLASH_HALF_PERIOD - 1);

   logic [FLASH_CNT_W-1:0] flash_cnt_q;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         flash_cnt_q <= '0;
         led_err_o <= 1'b0;
      end else if (!error_i) begin
         flash_cnt_q <= '0; // restart pattern on next error
         led_err_o <= 1'b0;
      end else if (flash_cnt_q == FLASH_LAST) begin
         flash_cnt_q <= '0;
         led_err_o <= ~led_err_o; // half period done
      end else begin
         flash_cnt_q <= flash_cnt_q + 1'b1;
      end
   end

   // lit whenever any source may be feeding the FIFO
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         led_armed_o <= 1'b0;
      end else begin
         led_armed_o <= armed_i | capture_on_i;
      end
   end

endmodule

`default_nettype wire

//--- tests/tb_husky.sv
`default_nettype none

module tb_husky;
   import husky_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int N_REG_LOOPS = 10;
   localparam int N_LA_RUNS = 8;
   localparam int MAX_LA_LEN = 12;
   localparam int N_TRACE_RUNS = 6;
   localparam int TRACE_MAX_CYCLES = 20;
   // roughly two cycles per register access, plus the fixed tests
   localparam int TEST_CYCLES = N_REG_LOOPS * 14 + N_LA_RUNS * (6 * MAX_LA_LEN + 20) +
                                N_TRACE_RUNS * (TRACE_MAX_CYCLES + 50) + 300;
   localparam int WATCHDOG_MARGIN = 3;

   logic clk_usb_buf;
   logic rst_i;
   reg_addr_t reg_addr_i;
   reg_data_t reg_wdata_i;
   logic reg_write_i;
   logic reg_read_i;
   sample_t la_probe_i;
   nibble_t trace_data_i;
   logic trace_valid_i;
   reg_data_t reg_rdata_o;
   logic led_err_o;
   logic led_armed_o;

   integer seed = 32'hdcf7f727;

   sample_t fifo_q[$]; // expected FIFO contents, head first
   reg_data_t m_samples;
   reg_data_t m_remain;
   reg_data_t m_trace_ctrl;
   reg_data_t m_rdata; // expected readback
   logic m_armed;
   logic m_half;
   nibble_t m_low;
   logic m_twr; // trace byte due at next edge
   sample_t m_tbyte;
   logic m_err;
   logic m_led_err;
   logic m_led_armed;
   int m_flash;

   husky_top i_dut (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .reg_addr_i    (reg_addr_i),
      .reg_wdata_i   (reg_wdata_i),
      .reg_write_i   (reg_write_i),
      .reg_read_i    (reg_read_i),
      .la_probe_i    (la_probe_i),
      .trace_data_i  (trace_data_i),
      .trace_valid_i (trace_valid_i),
      .reg_rdata_o   (reg_rdata_o),
      .led_err_o     (led_err_o),
      .led_armed_o   (led_armed_o)
   );

   initial begin
      clk_usb_buf = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb_buf = ~clk_usb_buf;
   end

   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic expect_data(input reg_data_t got, input reg_data_t exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("ERR at %0t: %s, got %h expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_count(input fifo_count_t got, input fifo_count_t exp,
                              input string what);
      if (got !== exp) begin
         abort_run($sformatf("ERR at %0t: %s, got %0d expected %0d", $time, what, got, exp));
      end
   endtask

   task automatic compare_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("ERR at %0t: %s, got %b expected %b", $time, what, got, exp));
      end
   endtask

   // probes and trace nibbles change every cycle
   initial begin
      la_probe_i = '0;
      trace_data_i = '0;
      trace_valid_i = 1'b0;
      forever begin
         @(posedge clk_usb_buf);
         la_probe_i <= sample_t'(rand32());
         trace_data_i <= nibble_t'(rand32());
         trace_valid_i <= rand32() > 32'h7fffffff; // random gaps
      end
   end

   function automatic reg_data_t expected_read(input reg_addr_t addr);
      case (addr)
         REG_TRACE_CTRL: return m_trace_ctrl;
         REG_LA_CTRL: return {7'b0, m_armed};
         REG_LA_SAMPLES: return m_samples;
         REG_FIFO_STATUS: return {5'b0, m_err, fifo_q.size() == FIFO_DEPTH, fifo_q.size() == 0};
         REG_FIFO_COUNT: return reg_data_t'(fifo_q.size());
         REG_FIFO_READ: return (fifo_q.size() == 0) ? 8'h00 : fifo_q[0];
         default: return 8'h00;
      endcase
   endfunction

   // cycle model, sees the inputs as the DUT samples them
   always @(posedge clk_usb_buf) begin : ref_model
      logic trace_on;
      logic armed_old;
      logic err_old;
      logic take;
      logic src_wr;
      sample_t src_data;
      logic flush;
      logic clr_err;
      logic was_full;
      if (rst_i) begin
         fifo_q.delete();
         m_samples = '0;
         m_remain = '0;
         m_trace_ctrl = '0;
         m_rdata = '0;
         m_armed = 1'b0;
         m_half = 1'b0;
         m_low = '0;
         m_twr = 1'b0;
         m_tbyte = '0;
         m_err = 1'b0;
         m_led_err = 1'b0;
         m_led_armed = 1'b0;
         m_flash = 0;
      end else begin
         trace_on = m_trace_ctrl[0];
         armed_old = m_armed;
         err_old = m_err;
         if (reg_read_i) begin
            m_rdata = expected_read(reg_addr_i);
         end
         src_wr = trace_on ? m_twr : (m_armed && m_remain != 0); // owner only
         src_data = trace_on ? m_tbyte : la_probe_i;
         flush = reg_write_i && reg_addr_i == REG_FIFO_STATUS && reg_wdata_i[0];
         clr_err = reg_write_i && reg_addr_i == REG_FIFO_STATUS && reg_wdata_i[1];
         was_full = fifo_q.size() == FIFO_DEPTH;
         if (flush) begin
            fifo_q.delete();
         end else begin
            if (reg_read_i && reg_addr_i == REG_FIFO_READ && fifo_q.size() != 0) begin
               void'(fifo_q.pop_front());
            end
            if (src_wr && !was_full) begin
               fifo_q.push_back(src_data);
            end
         end
         m_err = (m_err && !clr_err) || (src_wr && was_full && !flush);
         if (!err_old) begin
            m_flash = 0;
            m_led_err = 1'b0;
         end else if (m_flash == FLASH_HALF_PERIOD - 1) begin
            m_flash = 0;
            m_led_err = ~m_led_err;
         end else begin
            m_flash++;
         end
         m_led_armed = armed_old || trace_on;
         if (reg_write_i && reg_addr_i == REG_LA_CTRL) begin
            m_armed = reg_wdata_i[0];
            m_remain = m_samples; // length taken at arming
         end else if (m_armed) begin
            if (m_remain == 0) begin
               m_armed = 1'b0;
            end else begin
               m_remain = m_remain - 1'b1;
            end
         end
         if (reg_write_i && reg_addr_i == REG_LA_SAMPLES) begin
            m_samples = reg_wdata_i;
         end
         take = trace_on && trace_valid_i;
         m_twr = take && m_half;
         if (take && m_half) begin
            m_tbyte = {trace_data_i, m_low}; // low nibble came first
         end
         if (take && !m_half) begin
            m_low = trace_data_i;
         end
         if (reg_write_i && reg_addr_i == REG_TRACE_CTRL && !reg_wdata_i[0]) begin
            m_half = 1'b0;
         end else if (take) begin
            m_half = ~m_half;
         end
         if (reg_write_i && reg_addr_i == REG_TRACE_CTRL) begin
            m_trace_ctrl = reg_wdata_i;
         end
      end
   end

   always @(negedge clk_usb_buf) begin
      if (!rst_i) begin
         compare_bit(led_armed_o, m_led_armed, "armed LED");
         compare_bit(led_err_o, m_led_err, "error LED");
      end
   end

   task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
      @(posedge clk_usb_buf);
      reg_addr_i <= addr;
      reg_wdata_i <= data;
      reg_write_i <= 1'b1;
      @(posedge clk_usb_buf);
      reg_write_i <= 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output reg_data_t got);
      @(posedge clk_usb_buf);
      reg_addr_i <= addr;
      reg_read_i <= 1'b1;
      @(posedge clk_usb_buf);
      reg_read_i <= 1'b0;
      @(negedge clk_usb_buf); // one cycle after the strobe
      got = reg_rdata_o;
      expect_data(got, m_rdata, $sformatf("read of address %h", addr));
   endtask

   task automatic wait_disarmed(input int limit);
      reg_data_t ctrl;
      int polls;
      polls = 0;
      do begin
         read_reg(REG_LA_CTRL, ctrl);
         polls++;
         if (ctrl[0] && polls > limit) begin
            abort_run("LA capture never finished, armed stayed high");
         end
      end while (ctrl[0]);
   endtask

   task automatic drain_fifo();
      reg_data_t cnt;
      reg_data_t got;
      read_reg(REG_FIFO_COUNT, cnt);
      repeat (cnt) read_reg(REG_FIFO_READ, got); // each pop checked against the queue
      read_reg(REG_FIFO_STATUS, got);
      compare_bit(got[STAT_EMPTY_BIT], 1'b1, "empty after drain");
   endtask

   task automatic register_readback();
      reg_data_t val;
      reg_data_t got;
      for (int i = 0; i < N_REG_LOOPS; i++) begin
         val = reg_data_t'(rand32());
         write_reg(REG_LA_SAMPLES, val);
         read_reg(REG_LA_SAMPLES, got);
         expect_data(got, val, "sample count readback");
         val = reg_data_t'(rand32()) & 8'hfe; // capture stays off
         write_reg(REG_TRACE_CTRL, val);
         read_reg(REG_TRACE_CTRL, got);
         expect_data(got, val, "trace control readback");
         read_reg(8'h10 | reg_addr_t'(rand32()), got);
         expect_data(got, 8'h00, "unmapped address");
      end
      read_reg(8'h00, got);
      expect_data(got, 8'h00, "address zero");
      read_reg(8'h07, got);
      expect_data(got, 8'h00, "address above the map");
      write_reg(REG_TRACE_CTRL, 8'h00);
   endtask

   task automatic la_capture_runs();
      reg_data_t len;
      reg_data_t got;
      write_reg(REG_FIFO_STATUS, 8'h03);
      for (int run = 0; run < N_LA_RUNS; run++) begin
         len = reg_data_t'(rand32() % (MAX_LA_LEN + 1));
         write_reg(REG_LA_SAMPLES, len);
         write_reg(REG_LA_CTRL, 8'h01);
         wait_disarmed(MAX_LA_LEN + 4);
         read_reg(REG_FIFO_COUNT, got);
         check_count(fifo_count_t'(got), fifo_count_t'(len), "LA sample count");
         drain_fifo();
         read_reg(REG_LA_CTRL, got);
         expect_data(got, 8'h00, "armed after capture");
      end
   endtask

   task automatic trace_packing();
      int cycles;
      for (int run = 0; run < N_TRACE_RUNS; run++) begin
         write_reg(REG_FIFO_STATUS, 8'h01);
         write_reg(REG_TRACE_CTRL, 8'h01);
         cycles = 4 + int'(rand32() % TRACE_MAX_CYCLES);
         repeat (cycles) @(posedge clk_usb_buf);
         write_reg(REG_TRACE_CTRL, 8'h00); // a half byte is dropped here
         drain_fifo();
      end
   endtask

   task automatic source_select();
      write_reg(REG_FIFO_STATUS, 8'h03);
      write_reg(REG_TRACE_CTRL, 8'h01);
      write_reg(REG_LA_SAMPLES, 8'd8);
      write_reg(REG_LA_CTRL, 8'h01); // LA runs but must not reach the FIFO
      wait_disarmed(MAX_LA_LEN + 4);
      write_reg(REG_TRACE_CTRL, 8'h00);
      drain_fifo();
   endtask

   task automatic overflow_and_led();
      reg_data_t got;
      logic level;
      int waited;
      write_reg(REG_FIFO_STATUS, 8'h03);
      write_reg(REG_LA_SAMPLES, 8'd24);
      write_reg(REG_LA_CTRL, 8'h01);
      wait_disarmed(40);
      read_reg(REG_FIFO_COUNT, got);
      check_count(fifo_count_t'(got), fifo_count_t'(FIFO_DEPTH), "saturated count");
      read_reg(REG_FIFO_STATUS, got);
      compare_bit(got[STAT_FULL_BIT], 1'b1, "full flag");
      compare_bit(got[STAT_ERR_BIT], 1'b1, "overflow error flag");
      level = led_err_o;
      waited = 0;
      while (led_err_o == level) begin
         @(negedge clk_usb_buf);
         waited++;
         if (led_err_o == level && waited >= 2 * FLASH_HALF_PERIOD) begin
            abort_run("error LED did not flash after the overflow");
         end
      end
      write_reg(REG_FIFO_STATUS, 8'h02);
      repeat (2) @(negedge clk_usb_buf);
      repeat (3 * FLASH_HALF_PERIOD) begin
         @(negedge clk_usb_buf);
         compare_bit(led_err_o, 1'b0, "error LED after clear");
      end
      read_reg(REG_FIFO_STATUS, got);
      compare_bit(got[STAT_ERR_BIT], 1'b0, "error flag after clear");
      drain_fifo();
   endtask

   task automatic flush_and_empty_pop();
      reg_data_t got;
      write_reg(REG_LA_SAMPLES, 8'd5);
      write_reg(REG_LA_CTRL, 8'h01);
      wait_disarmed(MAX_LA_LEN + 4);
      write_reg(REG_FIFO_STATUS, 8'h01);
      read_reg(REG_FIFO_COUNT, got);
      check_count(fifo_count_t'(got), fifo_count_t'(0), "count after flush");
      read_reg(REG_FIFO_STATUS, got);
      compare_bit(got[STAT_EMPTY_BIT], 1'b1, "empty after flush");
      read_reg(REG_FIFO_READ, got);
      expect_data(got, 8'h00, "pop on empty FIFO");
   endtask

   initial begin
      rst_i = 1'b1;
      reg_addr_i = '0;
      reg_wdata_i = '0;
      reg_write_i = 1'b0;
      reg_read_i = 1'b0;
      repeat (2) @(posedge clk_usb_buf);
      rst_i <= 1'b0;
      register_readback();
      la_capture_runs();
      trace_packing();
      source_select();
      overflow_and_led();
      flush_and_empty_pop();
      repeat (4) @(posedge clk_usb_buf);
      $display("Test passed");
      $finish;
   end

   initial begin
      #(TEST_CYCLES * WATCHDOG_MARGIN * CLK_PERIOD);
      abort_run("watchdog expired before the tests finished");
   end

endmodule

`default_nettype wire
